/* Makefile */
TB = tb_decode_stage

all: run

run: obj_dir/V$(TB)
	./obj_dir/V$(TB)

obj_dir/V$(TB): decode_stage.f $(wildcard logic/*.sv test/*.sv)
	verilator --binary --timing -j 0 --top-module $(TB) -f decode_stage.f

lint:
	verilator --lint-only --timing --top-module decode_stage -f decode_stage.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

/* decode_stage.f */
logic/isa_pkg.sv
logic/ctrl_pkg.sv
logic/operand_bypass.sv
logic/inst_decoder.sv
logic/imm_gen.sv
logic/id_ex_reg.sv
logic/decode_stage.sv
test/clk_gen.sv
test/tb_decode_stage.sv

/* logic/ctrl_pkg.sv */
// Decode control encodings.
// Fields handed from the decode stage to execute.

package ctrl_pkg;

	typedef logic [2:0] alu_op_t; // same code as funct3.
	localparam alu_op_t alu_add = 3'b000;

	// branch funct3, or one of the two codes no branch uses
	typedef logic [2:0] jmp_flag_t;
	localparam jmp_flag_t jmp_j    = 3'b010;
	localparam jmp_flag_t jmp_none = 3'b011;

	typedef logic [2:0] load_code_t;
	localparam load_code_t load_none = 3'b111;

	typedef logic [2:0] store_code_t;
	localparam store_code_t store_none = 3'b111;

	typedef logic [1:0] except_cause_t;
	localparam except_cause_t cause_illegal = 2'd0;
	localparam except_cause_t cause_ecall   = 2'd1;
	localparam except_cause_t cause_ebreak  = 2'd2;
	localparam except_cause_t cause_mret    = 2'd3;

	typedef logic [1:0] src1_sel_t;
	localparam src1_sel_t src1_rs1  = 2'd0;
	localparam src1_sel_t src1_pc   = 2'd1;
	localparam src1_sel_t src1_imm  = 2'd2;
	localparam src1_sel_t src1_zero = 2'd3;

	typedef logic [1:0] src2_sel_t;
	localparam src2_sel_t src2_rs2  = 2'd0;
	localparam src2_sel_t src2_imm  = 2'd1;
	localparam src2_sel_t src2_step = 2'd2; // link address.
	localparam src2_sel_t src2_zero = 2'd3;

	typedef logic [2:0] imm_fmt_t;
	localparam imm_fmt_t imm_i = 3'd0;
	localparam imm_fmt_t imm_s = 3'd1;
	localparam imm_fmt_t imm_b = 3'd2;
	localparam imm_fmt_t imm_u = 3'd3;
	localparam imm_fmt_t imm_j = 3'd4;

endpackage

/* logic/decode_stage.sv */
// RV64I decode stage.
// Decode, bypass and immediate logic feeding the ID/EX register.

`timescale 1ns/1ps

module decode_stage (
	input  logic                    clk,
	input  logic                    rst_n,
	input  isa_pkg::instr_t         instr,
	input  isa_pkg::xdata_t         instr_pc,
	input  isa_pkg::xdata_t         rs1_rf,
	input  isa_pkg::xdata_t         rs2_rf,
	input  isa_pkg::reg_addr_t      fwd_addr,
	input  logic                    fwd_wr_en,
	input  isa_pkg::xdata_t         fwd_data,
	input  ctrl_pkg::load_code_t    fwd_load_code,
	output isa_pkg::reg_addr_t      rs1_addr,
	output isa_pkg::reg_addr_t      rs2_addr,
	output logic                    load_hazard,
	output isa_pkg::xdata_t         ex_alu_op_num1,
	output isa_pkg::xdata_t         ex_alu_op_num2,
	output isa_pkg::xdata_t         ex_jmp_op_num1,
	output isa_pkg::xdata_t         ex_jmp_op_num2,
	output ctrl_pkg::alu_op_t       ex_alu_op,
	output logic                    ex_alu_sub,
	output logic                    ex_alu_arith,
	output logic                    ex_word_op,
	output ctrl_pkg::jmp_flag_t     ex_jmp_flag,
	output ctrl_pkg::load_code_t    ex_load_code,
	output ctrl_pkg::store_code_t   ex_store_code,
	output isa_pkg::reg_addr_t      ex_rd_addr,
	output logic                    ex_reg_wr_en,
	output logic                    ex_except,
	output ctrl_pkg::except_cause_t ex_except_cause
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	xdata_t        rs1_data;
	xdata_t        rs2_data;
	xdata_t        imm;
	imm_fmt_t      imm_fmt;
	src1_sel_t     src1_sel;
	src2_sel_t     src2_sel;
	logic          jmp_base_pc;
	alu_op_t       alu_op;
	logic          alu_sub;
	logic          alu_arith;
	logic          word_op;
	jmp_flag_t     jmp_flag;
	load_code_t    load_code;
	store_code_t   store_code;
	reg_addr_t     rd_addr;
	logic          reg_wr_en;
	logic          except;
	except_cause_t except_cause;

	operand_bypass u_bypass (
		.rs1_addr      (rs1_addr),
		.rs2_addr      (rs2_addr),
		.rs1_rf        (rs1_rf),
		.rs2_rf        (rs2_rf),
		.fwd_addr      (fwd_addr),
		.fwd_wr_en     (fwd_wr_en),
		.fwd_data      (fwd_data),
		.fwd_load_code (fwd_load_code),
		.rs1_data      (rs1_data),
		.rs2_data      (rs2_data),
		.load_hazard   (load_hazard)
	);

	inst_decoder u_decoder (
		.instr        (instr),
		.rs1_addr     (rs1_addr),
		.rs2_addr     (rs2_addr),
		.rd_addr      (rd_addr),
		.reg_wr_en    (reg_wr_en),
		.alu_op       (alu_op),
		.alu_sub      (alu_sub),
		.alu_arith    (alu_arith),
		.word_op      (word_op),
		.jmp_flag     (jmp_flag),
		.load_code    (load_code),
		.store_code   (store_code),
		.src1_sel     (src1_sel),
		.src2_sel     (src2_sel),
		.jmp_base_pc  (jmp_base_pc),
		.imm_fmt      (imm_fmt),
		.except       (except),
		.except_cause (except_cause)
	);

	imm_gen u_imm_gen (
		.instr   (instr),
		.imm_fmt (imm_fmt),
		.imm     (imm)
	);

	id_ex_reg u_id_ex (
		.clk             (clk),
		.rst_n           (rst_n),
		.instr_pc        (instr_pc),
		.rs1_data        (rs1_data),
		.rs2_data        (rs2_data),
		.imm             (imm),
		.src1_sel        (src1_sel),
		.src2_sel        (src2_sel),
		.jmp_base_pc     (jmp_base_pc),
		.alu_op          (alu_op),
		.alu_sub         (alu_sub),
		.alu_arith       (alu_arith),
		.word_op         (word_op),
		.jmp_flag        (jmp_flag),
		.load_code       (load_code),
		.store_code      (store_code),
		.rd_addr         (rd_addr),
		.reg_wr_en       (reg_wr_en),
		.except          (except),
		.except_cause    (except_cause),
		.ex_alu_op_num1  (ex_alu_op_num1),
		.ex_alu_op_num2  (ex_alu_op_num2),
		.ex_jmp_op_num1  (ex_jmp_op_num1),
		.ex_jmp_op_num2  (ex_jmp_op_num2),
		.ex_alu_op       (ex_alu_op),
		.ex_alu_sub      (ex_alu_sub),
		.ex_alu_arith    (ex_alu_arith),
		.ex_word_op      (ex_word_op),
		.ex_jmp_flag     (ex_jmp_flag),
		.ex_load_code    (ex_load_code),
		.ex_store_code   (ex_store_code),
		.ex_rd_addr      (ex_rd_addr),
		.ex_reg_wr_en    (ex_reg_wr_en),
		.ex_except       (ex_except),
		.ex_except_cause (ex_except_cause)
	);

endmodule

/* logic/id_ex_reg.sv */
// ID/EX pipeline register.
// Picks ALU and jump operands and holds all decode results for execute.

`timescale 1ns/1ps

module id_ex_reg (
	input  logic                    clk,
	input  logic                    rst_n,
	input  isa_pkg::xdata_t         instr_pc,
	input  isa_pkg::xdata_t         rs1_data,
	input  isa_pkg::xdata_t         rs2_data,
	input  isa_pkg::xdata_t         imm,
	input  ctrl_pkg::src1_sel_t     src1_sel,
	input  ctrl_pkg::src2_sel_t     src2_sel,
	input  logic                    jmp_base_pc,
	input  ctrl_pkg::alu_op_t       alu_op,
	input  logic                    alu_sub,
	input  logic                    alu_arith,
	input  logic                    word_op,
	input  ctrl_pkg::jmp_flag_t     jmp_flag,
	input  ctrl_pkg::load_code_t    load_code,
	input  ctrl_pkg::store_code_t   store_code,
	input  isa_pkg::reg_addr_t      rd_addr,
	input  logic                    reg_wr_en,
	input  logic                    except,
	input  ctrl_pkg::except_cause_t except_cause,
	output isa_pkg::xdata_t         ex_alu_op_num1,
	output isa_pkg::xdata_t         ex_alu_op_num2,
	output isa_pkg::xdata_t         ex_jmp_op_num1,
	output isa_pkg::xdata_t         ex_jmp_op_num2,
	output ctrl_pkg::alu_op_t       ex_alu_op,
	output logic                    ex_alu_sub,
	output logic                    ex_alu_arith,
	output logic                    ex_word_op,
	output ctrl_pkg::jmp_flag_t     ex_jmp_flag,
	output ctrl_pkg::load_code_t    ex_load_code,
	output ctrl_pkg::store_code_t   ex_store_code,
	output isa_pkg::reg_addr_t      ex_rd_addr,
	output logic                    ex_reg_wr_en,
	output logic                    ex_except,
	output ctrl_pkg::except_cause_t ex_except_cause
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	xdata_t alu_num1;
	xdata_t alu_num2;
	xdata_t jmp_num1;
	xdata_t jmp_num2;

	always_comb begin
		case (src1_sel)
			src1_rs1: alu_num1 = rs1_data;
			src1_pc:  alu_num1 = instr_pc;
			src1_imm: alu_num1 = imm;
			default:  alu_num1 = '0;
		endcase

		case (src2_sel)
			src2_rs2:  alu_num2 = rs2_data;
			src2_imm:  alu_num2 = imm;
			src2_step: alu_num2 = pc_step;
			default:   alu_num2 = '0;
		endcase

		// jump base is rs1 only for jalr.
		if (jmp_flag == jmp_none) begin
			jmp_num1 = '0;
			jmp_num2 = '0;
		end else begin
			jmp_num1 = jmp_base_pc ? instr_pc : rs1_data;
			jmp_num2 = imm;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_alu_op_num1  <= '0;
			ex_alu_op_num2  <= '0;
			ex_jmp_op_num1  <= '0;
			ex_jmp_op_num2  <= '0;
			ex_alu_op       <= alu_add;
			ex_alu_sub      <= 1'b0;
			ex_alu_arith    <= 1'b0;
			ex_word_op      <= 1'b0;
			ex_jmp_flag     <= jmp_none;
			ex_load_code    <= load_none;
			ex_store_code   <= store_none;
			ex_rd_addr      <= '0;
			ex_reg_wr_en    <= 1'b0;
			ex_except       <= 1'b0;
			ex_except_cause <= cause_illegal;
		end else begin
			ex_alu_op_num1  <= alu_num1;
			ex_alu_op_num2  <= alu_num2;
			ex_jmp_op_num1  <= jmp_num1;
			ex_jmp_op_num2  <= jmp_num2;
			ex_alu_op       <= alu_op;
			ex_alu_sub      <= alu_sub;
			ex_alu_arith    <= alu_arith;
			ex_word_op      <= word_op;
			ex_jmp_flag     <= jmp_flag;
			ex_load_code    <= load_code;
			ex_store_code   <= store_code;
			ex_rd_addr      <= rd_addr;
			ex_reg_wr_en    <= reg_wr_en;
			ex_except       <= except;
			ex_except_cause <= except_cause;
		end
	end

endmodule

/* logic/imm_gen.sv */
// Immediate generator.
// Sign-extends the I, S, B, U or J immediate picked by decode.

`timescale 1ns/1ps

module imm_gen (
	input  isa_pkg::instr_t    instr,
	input  ctrl_pkg::imm_fmt_t imm_fmt,
	output isa_pkg::xdata_t    imm
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	logic sign;

	assign sign = instr[31];

	always_comb begin
		case (imm_fmt)
			imm_i:
				imm = {{(xlen-12){sign}}, instr.i.imm12};
			imm_s:
				imm = {{(xlen-12){sign}}, instr[31:25], instr[11:7]};
			imm_b:
				imm = {{(xlen-12){sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			imm_u:
				imm = {{(xlen-32){sign}}, instr[31:12], 12'h000};
			imm_j:
				imm = {{(xlen-20){sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			default:
				imm = '0;
		endcase
	end

endmodule

/* logic/inst_decoder.sv */
// Instruction decoder.
// Turns one RV64I word into ALU, jump, memory and writeback controls.
// Bad encodings and system traps leave a bubble with a cause.

`timescale 1ns/1ps

module inst_decoder (
	input  isa_pkg::instr_t         instr,
	output isa_pkg::reg_addr_t      rs1_addr,
	output isa_pkg::reg_addr_t      rs2_addr,
	output isa_pkg::reg_addr_t      rd_addr,
	output logic                    reg_wr_en,
	output ctrl_pkg::alu_op_t       alu_op,
	output logic                    alu_sub,
	output logic                    alu_arith,
	output logic                    word_op,
	output ctrl_pkg::jmp_flag_t     jmp_flag,
	output ctrl_pkg::load_code_t    load_code,
	output ctrl_pkg::store_code_t   store_code,
	output ctrl_pkg::src1_sel_t     src1_sel,
	output ctrl_pkg::src2_sel_t     src2_sel,
	output logic                    jmp_base_pc,
	output ctrl_pkg::imm_fmt_t      imm_fmt,
	output logic                    except,
	output ctrl_pkg::except_cause_t except_cause
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [5:0] funct6;

	assign opcode = instr.r.opcode;
	assign funct3 = instr.r.funct3;
	assign funct7 = instr.r.funct7;
	assign funct6 = instr.i.imm12[11:6];

	always_comb begin
		// defaults fit an I-type alu op.
		rs1_addr     = instr.i.rs1;
		rs2_addr     = '0;
		rd_addr      = instr.i.rd;
		reg_wr_en    = 1'b1;
		alu_op       = alu_add;
		alu_sub      = 1'b0;
		alu_arith    = 1'b0;
		word_op      = 1'b0;
		jmp_flag     = jmp_none;
		load_code    = load_none;
		store_code   = store_none;
		src1_sel     = src1_rs1;
		src2_sel     = src2_imm;
		jmp_base_pc  = 1'b0;
		imm_fmt      = imm_i;
		except       = 1'b0;
		except_cause = cause_illegal;

		case (opcode)
			op_r, op_rw: begin
				rs2_addr  = instr.r.rs2;
				src2_sel  = src2_rs2;
				alu_op    = funct3;
				word_op   = (opcode == op_rw);
				alu_sub   = (funct3 == f3_add) && (funct7 == f7_alt);
				alu_arith = (funct3 == f3_sr) && (funct7 == f7_alt);
				if (funct7 == f7_alt)
					except = !(funct3 inside {f3_add, f3_sr});
				else if (funct7 != f7_base)
					except = 1'b1;
				if (word_op && !(funct3 inside {f3_add, f3_sl, f3_sr}))
					except = 1'b1;
			end
			op_i: begin
				alu_op = funct3;
				if (funct3 == f3_sl)
					except = (funct6 != f6_base);
				else if (funct3 == f3_sr) begin
					alu_arith = (funct6 == f6_alt);
					except    = !(funct6 inside {f6_base, f6_alt});
				end
			end
			op_iw: begin
				alu_op    = funct3;
				word_op   = 1'b1;
				alu_arith = (funct3 == f3_sr) && (funct7 == f7_alt);
				if (funct3 == f3_sl)
					except = (funct7 != f7_base); // 5-bit shamt only.
				else if (funct3 == f3_sr)
					except = !(funct7 inside {f7_base, f7_alt});
				else
					except = (funct3 != f3_add);
			end
			op_lui: begin
				rs1_addr = '0;
				src1_sel = src1_imm;
				src2_sel = src2_zero;
				imm_fmt  = imm_u;
			end
			op_auipc: begin
				rs1_addr = '0;
				src1_sel = src1_pc;
				imm_fmt  = imm_u;
			end
			op_load: begin
				load_code = funct3;
				except    = (funct3 == 3'b111); // no ldu in rv64.
			end
			op_store: begin
				rs2_addr   = instr.r.rs2;
				rd_addr    = '0;
				reg_wr_en  = 1'b0;
				store_code = funct3;
				imm_fmt    = imm_s;
				except     = funct3[2]; // sb..sd only.
			end
			op_branch: begin
				rs2_addr    = instr.r.rs2;
				rd_addr     = '0;
				reg_wr_en   = 1'b0;
				src2_sel    = src2_rs2;
				jmp_flag    = funct3;
				jmp_base_pc = 1'b1;
				imm_fmt     = imm_b;
				except      = (funct3[2:1] == 2'b01); // 010 and 011 unused.
			end
			op_jal: begin
				rs1_addr    = '0;
				jmp_flag    = jmp_j;
				src1_sel    = src1_pc;
				src2_sel    = src2_step;
				jmp_base_pc = 1'b1;
				imm_fmt     = imm_j;
			end
			op_jalr: begin
				jmp_flag = jmp_j;
				src1_sel = src1_pc;
				src2_sel = src2_step;
				except   = (funct3 != 3'b000);
			end
			op_sys: begin
				// csr funct3 values fall through as illegal.
				except = 1'b1;
				if (funct3 == f3_irq) begin
					case (instr)
						instr_ecall:  except_cause = cause_ecall;
						instr_ebreak: except_cause = cause_ebreak;
						instr_mret:   except_cause = cause_mret;
						default:      except_cause = cause_illegal;
					endcase
				end
			end
			default: except = 1'b1;
		endcase

		if (except) begin
			rs1_addr    = '0;
			rs2_addr    = '0;
			rd_addr     = '0;
			reg_wr_en   = 1'b0;
			alu_op      = alu_add;
			alu_sub     = 1'b0;
			alu_arith   = 1'b0;
			word_op     = 1'b0;
			jmp_flag    = jmp_none;
			load_code   = load_none;
			store_code  = store_none;
			src1_sel    = src1_zero;
			src2_sel    = src2_zero;
			jmp_base_pc = 1'b0;
			imm_fmt     = imm_i;
		end
	end

endmodule

/* logic/isa_pkg.sv */
// RV64I instruction set definitions.
// Opcodes, funct fields, system words and the instruction word views.

package isa_pkg;

	localparam int xlen = 64;

	typedef logic [4:0]      reg_addr_t;
	typedef logic [xlen-1:0] xdata_t;

	localparam logic [6:0] op_r      = 7'b0110011;
	localparam logic [6:0] op_rw     = 7'b0111011;
	localparam logic [6:0] op_i      = 7'b0010011;
	localparam logic [6:0] op_iw     = 7'b0011011;
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_sys    = 7'b1110011;

	localparam logic [2:0] f3_add  = 3'b000;
	localparam logic [2:0] f3_sl   = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_sr   = 3'b101;
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;
	localparam logic [2:0] f3_irq  = 3'b000; // ecall, ebreak, mret.

	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_alt  = 7'b0100000; // sub, sra.

	// upper six bits of imm12 for rv64 shift immediates
	localparam logic [5:0] f6_base = 6'b000000;
	localparam logic [5:0] f6_alt  = 6'b010000;

	localparam logic [31:0] instr_ecall  = 32'h0000_0073;
	localparam logic [31:0] instr_ebreak = 32'h0010_0073;
	localparam logic [31:0] instr_mret   = 32'h3020_0073;

	localparam xdata_t pc_step = 64'd4;

	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			reg_addr_t  rs2;
			reg_addr_t  rs1;
			logic [2:0] funct3;
			reg_addr_t  rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm12;
			reg_addr_t   rs1;
			logic [2:0]  funct3;
			reg_addr_t   rd;
			logic [6:0]  opcode;
		} i;
	} instr_t;

endpackage

/* logic/operand_bypass.sv */
// Operand bypass.
// Replaces register-file data with the next stage's result and flags load-use.

`timescale 1ns/1ps

module operand_bypass (
	input  isa_pkg::reg_addr_t   rs1_addr,
	input  isa_pkg::reg_addr_t   rs2_addr,
	input  isa_pkg::xdata_t      rs1_rf,
	input  isa_pkg::xdata_t      rs2_rf,
	input  isa_pkg::reg_addr_t   fwd_addr,
	input  logic                 fwd_wr_en,
	input  isa_pkg::xdata_t      fwd_data,
	input  ctrl_pkg::load_code_t fwd_load_code,
	output isa_pkg::xdata_t      rs1_data,
	output isa_pkg::xdata_t      rs2_data,
	output logic                 load_hazard
);
	import ctrl_pkg::*;

	logic fwd_rs1;
	logic fwd_rs2;

	// x0 is not excluded here.
	assign fwd_rs1 = fwd_wr_en && (rs1_addr == fwd_addr);
	assign fwd_rs2 = fwd_wr_en && (rs2_addr == fwd_addr);

	assign rs1_data = fwd_rs1 ? fwd_data : rs1_rf;
	assign rs2_data = fwd_rs2 ? fwd_data : rs2_rf;

	// load data is not ready yet.
	assign load_hazard = (fwd_rs1 || fwd_rs2) && (fwd_load_code != load_none);

endmodule

/* test/clk_gen.sv */
// Clock and reset source for the decode stage testbench.
// 8 ns clock, reset held low for a fixed number of cycles.

`timescale 1ns/1ps

module clk_gen #(
	parameter int reset_cycles = 10
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#1 rst_n = 1'b1; // released off the edge.
	end

endmodule

/* test/tb_decode_stage.sv */
// Testbench for the RV64I decode stage.
// Applies a table of instructions with expected decode results, one per cycle,
// checking bypass outputs in the same cycle and registered outputs one cycle later.

`timescale 1ns/1ps

module tb_decode_stage;
	import isa_pkg::*;
	import ctrl_pkg::*;

	localparam int reset_cycles   = 10;
	localparam int n_rows         = 24;
	localparam int timeout_cycles = n_rows + reset_cycles + 20;

	typedef struct packed {
		logic [31:0]   instr;
		xdata_t        pc;
		xdata_t        rs1_rf;
		xdata_t        rs2_rf;
		reg_addr_t     fwd_addr;
		logic          fwd_wr_en;
		xdata_t        fwd_data;
		load_code_t    fwd_load_code;
		reg_addr_t     rs1_addr;
		reg_addr_t     rs2_addr;
		logic          load_hazard;
		xdata_t        num1;
		xdata_t        num2;
		xdata_t        jnum1;
		xdata_t        jnum2;
		alu_op_t       alu_op;
		logic          alu_sub;
		logic          alu_arith;
		logic          word_op;
		jmp_flag_t     jmp_flag;
		load_code_t    load_code;
		store_code_t   store_code;
		reg_addr_t     rd_addr;
		logic          reg_wr_en;
		logic          except;
		except_cause_t cause;
	} row_t;

	logic          clk;
	logic          rst_n;
	logic [31:0]   instr;
	xdata_t        instr_pc;
	xdata_t        rs1_rf;
	xdata_t        rs2_rf;
	reg_addr_t     fwd_addr;
	logic          fwd_wr_en;
	xdata_t        fwd_data;
	load_code_t    fwd_load_code;
	reg_addr_t     rs1_addr;
	reg_addr_t     rs2_addr;
	logic          load_hazard;
	xdata_t        ex_alu_op_num1;
	xdata_t        ex_alu_op_num2;
	xdata_t        ex_jmp_op_num1;
	xdata_t        ex_jmp_op_num2;
	alu_op_t       ex_alu_op;
	logic          ex_alu_sub;
	logic          ex_alu_arith;
	logic          ex_word_op;
	jmp_flag_t     ex_jmp_flag;
	load_code_t    ex_load_code;
	store_code_t   ex_store_code;
	reg_addr_t     ex_rd_addr;
	logic          ex_reg_wr_en;
	logic          ex_except;
	except_cause_t ex_except_cause;

	row_t        rows [n_rows];
	row_t        r;
	int          n_built = 0;
	int          cycles  = 0;
	logic [31:0] lfsr    = 32'h860c_5548;

	clk_gen #(.reset_cycles(reset_cycles)) u_clk (
		.clk   (clk),
		.rst_n (rst_n)
	);

	decode_stage u_dut (
		.clk             (clk),
		.rst_n           (rst_n),
		.instr           (instr),
		.instr_pc        (instr_pc),
		.rs1_rf          (rs1_rf),
		.rs2_rf          (rs2_rf),
		.fwd_addr        (fwd_addr),
		.fwd_wr_en       (fwd_wr_en),
		.fwd_data        (fwd_data),
		.fwd_load_code   (fwd_load_code),
		.rs1_addr        (rs1_addr),
		.rs2_addr        (rs2_addr),
		.load_hazard     (load_hazard),
		.ex_alu_op_num1  (ex_alu_op_num1),
		.ex_alu_op_num2  (ex_alu_op_num2),
		.ex_jmp_op_num1  (ex_jmp_op_num1),
		.ex_jmp_op_num2  (ex_jmp_op_num2),
		.ex_alu_op       (ex_alu_op),
		.ex_alu_sub      (ex_alu_sub),
		.ex_alu_arith    (ex_alu_arith),
		.ex_word_op      (ex_word_op),
		.ex_jmp_flag     (ex_jmp_flag),
		.ex_load_code    (ex_load_code),
		.ex_store_code   (ex_store_code),
		.ex_rd_addr      (ex_rd_addr),
		.ex_reg_wr_en    (ex_reg_wr_en),
		.ex_except       (ex_except),
		.ex_except_cause (ex_except_cause)
	);

	// galois lfsr stepped once per bit.
	function automatic logic [63:0] rand64();
		logic [63:0] w;
		w = '0;
		for (int k = 0; k < 64; k++) begin
			w = {w[62:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return w;
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
			input logic [6:0] op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
	endfunction

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
			input string what);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("Some tests failed");
			$fatal(1, "mismatch");
		end
	endtask

	// every row starts as a plain bubble with fresh random data.
	task automatic start_row(input logic [31:0] word);
		r = '0;
		r.instr         = word;
		r.pc            = rand64();
		r.rs1_rf        = rand64();
		r.rs2_rf        = rand64();
		r.fwd_data      = rand64();
		r.fwd_load_code = load_none;
		r.jmp_flag      = jmp_none;
		r.load_code     = load_none;
		r.store_code    = store_none;
		r.cause         = cause_illegal;
	endtask

	task automatic set_ctl(input reg_addr_t rs1a, input reg_addr_t rs2a, input reg_addr_t rd,
			input logic wr, input alu_op_t op, input logic sub, input logic arith,
			input logic word);
		r.rs1_addr  = rs1a;
		r.rs2_addr  = rs2a;
		r.rd_addr   = rd;
		r.reg_wr_en = wr;
		r.alu_op    = op;
		r.alu_sub   = sub;
		r.alu_arith = arith;
		r.word_op   = word;
	endtask

	task automatic set_fwd(input reg_addr_t addr, input logic wr, input load_code_t code,
			input logic hazard);
		r.fwd_addr      = addr;
		r.fwd_wr_en     = wr;
		r.fwd_load_code = code;
		r.load_hazard   = hazard;
	endtask

	task automatic finish_row(input xdata_t n1, input xdata_t n2, input xdata_t j1,
			input xdata_t j2);
		r.num1  = n1;
		r.num2  = n2;
		r.jnum1 = j1;
		r.jnum2 = j2;
		if (n_built < n_rows)
			rows[n_built] = r;
		n_built++;
	endtask

	task automatic bubble_row(input except_cause_t cause);
		r.except = 1'b1;
		r.cause  = cause;
		finish_row(64'd0, 64'd0, 64'd0, 64'd0);
	endtask

	task automatic build_table();
		// register-register and word classes.
		start_row(enc_r(f7_alt, 5'd7, 5'd6, f3_add, 5'd5, op_r));
		set_ctl(5'd6, 5'd7, 5'd5, 1'b1, f3_add, 1'b1, 1'b0, 1'b0);
		finish_row(r.rs1_rf, r.rs2_rf, 64'd0, 64'd0);
		start_row(enc_r(f7_alt, 5'd10, 5'd9, f3_sr, 5'd8, op_rw));
		set_ctl(5'd9, 5'd10, 5'd8, 1'b1, f3_sr, 1'b0, 1'b1, 1'b1);
		finish_row(r.rs1_rf, r.rs2_rf, 64'd0, 64'd0);
		start_row(enc_r(f7_base, 5'd13, 5'd12, f3_xor, 5'd11, op_r));
		set_ctl(5'd12, 5'd13, 5'd11, 1'b1, f3_xor, 1'b0, 1'b0, 1'b0);
		finish_row(r.rs1_rf, r.rs2_rf, 64'd0, 64'd0);
		// immediate classes.
		start_row(enc_i(12'hffb, 5'd2, f3_add, 5'd1, op_i));
		set_ctl(5'd2, 5'd0, 5'd1, 1'b1, f3_add, 1'b0, 1'b0, 1'b0);
		finish_row(r.rs1_rf, 64'hffff_ffff_ffff_fffb, 64'd0, 64'd0);
		start_row(enc_i(12'h403, 5'd5, f3_sr, 5'd4, op_iw));
		set_ctl(5'd5, 5'd0, 5'd4, 1'b1, f3_sr, 1'b0, 1'b1, 1'b1);
		finish_row(r.rs1_rf, 64'h403, 64'd0, 64'd0);
		start_row(enc_i(12'h423, 5'd7, f3_sr, 5'd6, op_i)); // srai by 35.
		set_ctl(5'd7, 5'd0, 5'd6, 1'b1, f3_sr, 1'b0, 1'b1, 1'b0);
		finish_row(r.rs1_rf, 64'h423, 64'd0, 64'd0);
		start_row({20'h80001, 5'd9, op_lui});
		set_ctl(5'd0, 5'd0, 5'd9, 1'b1, f3_add, 1'b0, 1'b0, 1'b0);
		finish_row(64'hffff_ffff_8000_1000, 64'd0, 64'd0, 64'd0);
		start_row({20'h12345, 5'd10, op_auipc});
		set_ctl(5'd0, 5'd0, 5'd10, 1'b1, f3_add, 1'b0, 1'b0, 1'b0);
		finish_row(r.pc, 64'h1234_5000, 64'd0, 64'd0);
		start_row(enc_i(12'hff0, 5'd12, 3'b011, 5'd11, op_load));
		set_ctl(5'd12, 5'd0, 5'd11, 1'b1, f3_add, 1'b0, 1'b0, 1'b0);
		r.load_code = 3'b011;
		finish_row(r.rs1_rf, 64'hffff_ffff_ffff_fff0, 64'd0, 64'd0);
		start_row(enc_s(12'd100, 5'd13, 5'd14, 3'b010));
		set_ctl(5'd14, 5'd13, 5'd0, 1'b0, f3_add, 1'b0, 1'b0, 1'b0);
		r.store_code = 3'b010;
		finish_row(r.rs1_rf, 64'd100, 64'd0, 64'd0);
		// control flow.
		start_row(enc_b(13'h1f00, 5'd16, 5'd15, 3'b001));
		set_ctl(5'd15, 5'd16, 5'd0, 1'b0, f3_add, 1'b0, 1'b0, 1'b0);
		r.jmp_flag = 3'b001;
		finish_row(r.rs1_rf, r.rs2_rf, r.pc, 64'hffff_ffff_ffff_ff00);
		start_row(enc_b(13'h0802, 5'd18, 5'd17, 3'b111));
		set_ctl(5'd17, 5'd18, 5'd0, 1'b0, f3_add, 1'b0, 1'b0, 1'b0);
		r.jmp_flag = 3'b111;
		finish_row(r.rs1_rf, r.rs2_rf, r.pc, 64'h802);
		start_row(enc_j(21'h1f_db98, 5'd1));
		set_ctl(5'd0, 5'd0, 5'd1, 1'b1, f3_add, 1'b0, 1'b0, 1'b0);
		r.jmp_flag = jmp_j;
		finish_row(r.pc, 64'd4, r.pc, 64'hffff_ffff_ffff_db98);
		start_row(enc_i(12'd40, 5'd6, 3'b000, 5'd5, op_jalr));
		set_ctl(5'd6, 5'd0, 5'd5, 1'b1, f3_add, 1'b0, 1'b0, 1'b0);
		r.jmp_flag = jmp_j;
		finish_row(r.pc, 64'd4, r.rs1_rf, 64'd40);
		// forwarding from the next stage.
		start_row(enc_r(f7_base, 5'd2, 5'd1, f3_add, 5'd3, op_r));
		set_ctl(5'd1, 5'd2, 5'd3, 1'b1, f3_add, 1'b0, 1'b0, 1'b0);
		set_fwd(5'd1, 1'b1, load_none, 1'b0);
		finish_row(r.fwd_data, r.rs2_rf, 64'd0, 64'd0);
		start_row(enc_r(f7_base, 5'd2, 5'd1, f3_add, 5'd3, op_r));
		set_ctl(5'd1, 5'd2, 5'd3, 1'b1, f3_add, 1'b0, 1'b0, 1'b0);
		set_fwd(5'd2, 1'b0, 3'b011, 1'b0); // write enable low.
		finish_row(r.rs1_rf, r.rs2_rf, 64'd0, 64'd0);
		start_row(enc_r(f7_base, 5'd2, 5'd1, f3_add, 5'd3, op_r));
		set_ctl(5'd1, 5'd2, 5'd3, 1'b1, f3_add, 1'b0, 1'b0, 1'b0);
		set_fwd(5'd2, 1'b1, 3'b010, 1'b1);
		finish_row(r.rs1_rf, r.fwd_data, 64'd0, 64'd0);
		start_row(enc_i(12'd40, 5'd6, 3'b000, 5'd5, op_jalr));
		set_ctl(5'd6, 5'd0, 5'd5, 1'b1, f3_add, 1'b0, 1'b0, 1'b0);
		set_fwd(5'd6, 1'b1, 3'b000, 1'b1);
		r.jmp_flag = jmp_j;
		finish_row(r.pc, 64'd4, r.fwd_data, 64'd40);
		// illegal encodings and system traps.
		start_row(enc_r(7'b0000001, 5'd2, 5'd1, f3_add, 5'd3, op_r));
		bubble_row(cause_illegal);
		start_row(32'h0000_0000);
		bubble_row(cause_illegal);
		start_row(enc_i(12'h300, 5'd2, 3'b001, 5'd1, op_sys)); // csrrw.
		bubble_row(cause_illegal);
		start_row(instr_ecall);
		bubble_row(cause_ecall);
		start_row(instr_ebreak);
		bubble_row(cause_ebreak);
		start_row(instr_mret);
		bubble_row(cause_mret);
	endtask

	task automatic apply_row(input row_t e);
		instr         = e.instr;
		instr_pc      = e.pc;
		rs1_rf        = e.rs1_rf;
		rs2_rf        = e.rs2_rf;
		fwd_addr      = e.fwd_addr;
		fwd_wr_en     = e.fwd_wr_en;
		fwd_data      = e.fwd_data;
		fwd_load_code = e.fwd_load_code;
	endtask

	task automatic check_registered(input row_t e, input string tag);
		check_value(ex_alu_op_num1, e.num1, {tag, " alu operand 1"});
		check_value(ex_alu_op_num2, e.num2, {tag, " alu operand 2"});
		check_value(ex_jmp_op_num1, e.jnum1, {tag, " jump operand 1"});
		check_value(ex_jmp_op_num2, e.jnum2, {tag, " jump operand 2"});
		check_value(64'(ex_alu_op), 64'(e.alu_op), {tag, " alu_op"});
		check_value(64'(ex_alu_sub), 64'(e.alu_sub), {tag, " alu_sub"});
		check_value(64'(ex_alu_arith), 64'(e.alu_arith), {tag, " alu_arith"});
		check_value(64'(ex_word_op), 64'(e.word_op), {tag, " word_op"});
		check_value(64'(ex_jmp_flag), 64'(e.jmp_flag), {tag, " jmp_flag"});
		check_value(64'(ex_load_code), 64'(e.load_code), {tag, " load_code"});
		check_value(64'(ex_store_code), 64'(e.store_code), {tag, " store_code"});
		check_value(64'(ex_rd_addr), 64'(e.rd_addr), {tag, " rd_addr"});
		check_value(64'(ex_reg_wr_en), 64'(e.reg_wr_en), {tag, " reg_wr_en"});
		check_value(64'(ex_except), 64'(e.except), {tag, " except"});
		check_value(64'(ex_except_cause), 64'(e.cause), {tag, " except_cause"});
	endtask

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > timeout_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", timeout_cycles);
			$display("Some tests failed");
			$fatal(1, "timeout");
		end
	end

	initial begin
		row_t idle;
		instr         = '0;
		instr_pc      = '0;
		rs1_rf        = '0;
		rs2_rf        = '0;
		fwd_addr      = '0;
		fwd_wr_en     = 1'b0;
		fwd_data      = '0;
		fwd_load_code = load_none;
		build_table();
		if (n_built != n_rows) begin
			$display("the stimulus table holds %0d rows instead of %0d", n_built, n_rows);
			$display("Some tests failed");
			$fatal(1, "table size");
		end
		// a live instruction during reset must not reach the register.
		start_row(32'h0000_0000);
		idle = r;
		repeat (3) @(posedge clk);
		#1 apply_row(rows[0]);
		@(posedge clk);
		#1 check_registered(idle, "in reset");
		@(posedge rst_n);
		#1 check_registered(idle, "after reset");
		for (int i = 0; i <= n_rows; i++) begin
			@(posedge clk);
			#1;
			if (i > 0)
				check_registered(rows[i-1], $sformatf("row %0d", i - 1));
			if (i < n_rows) begin
				apply_row(rows[i]);
				#1;
				check_value(64'(rs1_addr), 64'(rows[i].rs1_addr),
					$sformatf("row %0d rs1_addr", i));
				check_value(64'(rs2_addr), 64'(rows[i].rs2_addr),
					$sformatf("row %0d rs2_addr", i));
				check_value(64'(load_hazard), 64'(rows[i].load_hazard),
					$sformatf("row %0d load_hazard", i));
			end
		end
		$display("All tests passed");
		$finish;
	end

endmodule
